//--- hdl/ooo_pkg.sv
package ooo_pkg;

    // widest tag any configuration may carry in the shared structs
    localparam int MAX_TAG_W = 4;

    // multiplier pipeline depth in cycles
    localparam int MUL_LATENCY = 3;

    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_addi = 3'd5,
        op_mul  = 3'd6
    } opcode_e;

    // decoded instruction as it arrives from the front end
    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } instr_t;

    // one operation handed to an execution unit
    typedef struct packed {
        logic                 valid;
        opcode_e              op;
        logic [31:0]          opnd_a;
        logic [31:0]          opnd_b;
        logic [MAX_TAG_W-1:0] tag;
    } issue_t;

    // completion into the reorder buffer
    typedef struct packed {
        logic                 valid;
        logic [MAX_TAG_W-1:0] tag;
        logic [31:0]          value;
    } wb_t;

    // in-order retirement into the register file
    typedef struct packed {
        logic                 valid;
        logic [4:0]           rd;
        logic [31:0]          value;
        logic [MAX_TAG_W-1:0] tag;
    } commit_t;

endpackage

//--- hdl/regfile_scoreboard.sv
module regfile_scoreboard
    import ooo_pkg::*;
#(
    parameter int ROB_IDX_W = 2
) (
    input  logic                 clk,
    input  logic                 rst,

    // retirement from the reorder buffer
    input  commit_t              commit,

    // newest writer of a register, set on dispatch
    input  logic                 issue_valid,
    input  logic [4:0]           issue_rd,
    input  logic [ROB_IDX_W-1:0] issue_tag,

    // source reads for the instruction at dispatch
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    output logic [31:0]          rs1_value,
    output logic [31:0]          rs2_value,
    output logic                 rs1_ready,
    output logic                 rs2_ready,
    output logic [ROB_IDX_W-1:0] rs1_tag,
    output logic [ROB_IDX_W-1:0] rs2_tag
);

    logic [31:0]          value_q [32];
    logic [ROB_IDX_W-1:0] tag_q [32];
    logic [31:0]          busy_q;

    logic commit_wr;
    logic commit_is_newest;

    always_comb begin
        commit_wr        = commit.valid && (commit.rd != 5'd0);
        commit_is_newest = busy_q[commit.rd] &&
                           (tag_q[commit.rd] == commit.tag[ROB_IDX_W-1:0]);
    end

    // architectural state starts at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                value_q[i] <= '0;
                tag_q[i]   <= '0;
            end
            busy_q <= '0;
        end else begin
            if (commit_wr) begin
                value_q[commit.rd] <= commit.value;
                // an older writer retiring leaves the newer producer in place
                if (commit_is_newest) begin
                    busy_q[commit.rd] <= 1'b0;
                end
            end
            // same-cycle dispatch wins over the clear
            if (issue_valid && (issue_rd != 5'd0)) begin
                tag_q[issue_rd]  <= issue_tag;
                busy_q[issue_rd] <= 1'b1;
            end
        end
    end

    always_comb begin
        rs1_value = value_q[rs1];
        rs2_value = value_q[rs2];
        rs1_ready = ~busy_q[rs1];
        rs2_ready = ~busy_q[rs2];
        rs1_tag   = tag_q[rs1];
        rs2_tag   = tag_q[rs2];
    end

endmodule

//--- hdl/reorder_buffer.sv
module reorder_buffer
    import ooo_pkg::*;
#(
    parameter int ROB_IDX_W = 2
) (
    input  logic                 clk,
    input  logic                 rst,

    // allocation at the tail
    input  logic                 alloc_valid,
    input  logic [4:0]           alloc_rd,
    output logic [ROB_IDX_W-1:0] alloc_tag,
    output logic                 alloc_full,

    // completions from the execution units
    input  wb_t                  alu_wb,
    input  wb_t                  mul_wb,

    // operand lookup by producer tag
    input  logic [ROB_IDX_W-1:0] lookup_tag_a,
    input  logic [ROB_IDX_W-1:0] lookup_tag_b,
    output logic                 lookup_done_a,
    output logic                 lookup_done_b,
    output logic [31:0]          lookup_value_a,
    output logic [31:0]          lookup_value_b,

    // in-order retirement
    output commit_t              commit
);

    localparam int DEPTH = 1 << ROB_IDX_W;

    logic [4:0]           rd_q [DEPTH];
    logic [31:0]          value_q [DEPTH];
    logic [DEPTH-1:0]     done_q;
    logic [ROB_IDX_W-1:0] head_q;
    logic [ROB_IDX_W-1:0] tail_q;
    logic [ROB_IDX_W:0]   count_q;

    logic                 retire;
    logic [ROB_IDX_W-1:0] alu_idx;
    logic [ROB_IDX_W-1:0] mul_idx;

    always_comb begin
        alu_idx    = alu_wb.tag[ROB_IDX_W-1:0];
        mul_idx    = mul_wb.tag[ROB_IDX_W-1:0];
        alloc_tag  = tail_q;
        alloc_full = (count_q == (ROB_IDX_W+1)'(DEPTH));
        // head retires as soon as its result is in
        retire     = (count_q != '0) && done_q[head_q];
    end

    // pointers, occupancy and done bits
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_valid) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end

            // completions land out of order
            if (alu_wb.valid) begin
                done_q[alu_idx] <= 1'b1;
            end
            if (mul_wb.valid) begin
                done_q[mul_idx] <= 1'b1;
            end

            case ({alloc_valid, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rd_q[tail_q] <= alloc_rd;
        end
        if (alu_wb.valid) begin
            value_q[alu_idx] <= alu_wb.value;
        end
        if (mul_wb.valid) begin
            value_q[mul_idx] <= mul_wb.value;
        end
    end

    always_comb begin
        lookup_done_a  = done_q[lookup_tag_a];
        lookup_done_b  = done_q[lookup_tag_b];
        lookup_value_a = value_q[lookup_tag_a];
        lookup_value_b = value_q[lookup_tag_b];
    end

    always_comb begin
        commit.valid = retire;
        commit.rd    = rd_q[head_q];
        commit.value = value_q[head_q];
        commit.tag   = MAX_TAG_W'(head_q);
    end

endmodule

//--- hdl/dispatch_unit.sv
module dispatch_unit
    import ooo_pkg::*;
#(
    parameter int ROB_IDX_W = 2
) (
    input  logic                 clk,
    input  logic                 rst,

    // instruction input
    input  logic                 in_valid,
    input  instr_t               in_instr,
    output logic                 in_ready,

    // reorder buffer allocation
    output logic                 alloc_valid,
    output logic [4:0]           alloc_rd,
    input  logic [ROB_IDX_W-1:0] alloc_tag,
    input  logic                 alloc_full,

    // register file scoreboard
    output logic                 issue_valid,
    output logic [4:0]           issue_rd,
    output logic [ROB_IDX_W-1:0] issue_tag,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    input  logic [31:0]          rs1_value,
    input  logic [31:0]          rs2_value,
    input  logic                 rs1_ready,
    input  logic                 rs2_ready,
    input  logic [ROB_IDX_W-1:0] rs1_tag,
    input  logic [ROB_IDX_W-1:0] rs2_tag,

    // reorder buffer operand lookup
    output logic [ROB_IDX_W-1:0] lookup_tag_a,
    output logic [ROB_IDX_W-1:0] lookup_tag_b,
    input  logic                 lookup_done_a,
    input  logic                 lookup_done_b,
    input  logic [31:0]          lookup_value_a,
    input  logic [31:0]          lookup_value_b,

    // execution units
    output issue_t               alu_issue,
    output issue_t               mul_issue
);

    logic        src_a_ok;
    logic        src_b_ok;
    logic        use_imm;
    logic        is_mul;
    logic        accept;
    logic [31:0] opnd_a;
    logic [31:0] opnd_b;

    // one payload register serves both units, only one valid at a time
    logic                 alu_vld_q;
    logic                 mul_vld_q;
    opcode_e              op_q;
    logic [31:0]          opnd_a_q;
    logic [31:0]          opnd_b_q;
    logic [ROB_IDX_W-1:0] tag_q;

    always_comb begin
        rs1          = in_instr.rs1;
        rs2          = in_instr.rs2;
        lookup_tag_a = rs1_tag;
        lookup_tag_b = rs2_tag;
        use_imm      = (in_instr.op == op_addi);
        is_mul       = (in_instr.op == op_mul);

        // committed value first, else a finished but unretired producer
        src_a_ok = rs1_ready || lookup_done_a;
        opnd_a   = rs1_ready ? rs1_value : lookup_value_a;
        src_b_ok = use_imm || rs2_ready || lookup_done_b;
        opnd_b   = use_imm ? in_instr.imm : (rs2_ready ? rs2_value : lookup_value_b);

        in_ready = !alloc_full && src_a_ok && src_b_ok;
        accept   = in_valid && in_ready;

        alloc_valid = accept;
        alloc_rd    = in_instr.rd;
        issue_valid = accept;
        issue_rd    = in_instr.rd;
        issue_tag   = alloc_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_vld_q <= 1'b0;
            mul_vld_q <= 1'b0;
        end else begin
            alu_vld_q <= accept && !is_mul;
            mul_vld_q <= accept && is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= in_instr.op;
            opnd_a_q <= opnd_a;
            opnd_b_q <= opnd_b;
            tag_q    <= alloc_tag;
        end
    end

    always_comb begin
        alu_issue = '{valid: alu_vld_q, op: op_q, opnd_a: opnd_a_q, opnd_b: opnd_b_q,
                      tag: MAX_TAG_W'(tag_q)};
        mul_issue = '{valid: mul_vld_q, op: op_q, opnd_a: opnd_a_q, opnd_b: opnd_b_q,
                      tag: MAX_TAG_W'(tag_q)};
    end

endmodule

//--- hdl/int_alu.sv
module int_alu
    import ooo_pkg::*;
#(
    parameter int ROB_IDX_W = 2
) (
    input  logic   clk,
    input  logic   rst,
    input  issue_t issue,
    output wb_t    wb
);

    logic [31:0]          result;
    logic                 valid_q;
    logic [ROB_IDX_W-1:0] tag_q;
    logic [31:0]          value_q;

    always_comb begin
        case (issue.op)
            op_add,
            op_addi: result = issue.opnd_a + issue.opnd_b;
            op_sub:  result = issue.opnd_a - issue.opnd_b;
            op_and:  result = issue.opnd_a & issue.opnd_b;
            op_or:   result = issue.opnd_a | issue.opnd_b;
            op_xor:  result = issue.opnd_a ^ issue.opnd_b;
            // multiplies never reach this unit
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        tag_q   <= issue.tag[ROB_IDX_W-1:0];
        value_q <= result;
    end

    assign wb = '{valid: valid_q, tag: MAX_TAG_W'(tag_q), value: value_q};

endmodule

//--- hdl/mul_unit.sv
module mul_unit
    import ooo_pkg::*;
#(
    parameter int ROB_IDX_W = 2
) (
    input  logic   clk,
    input  logic   rst,
    input  issue_t issue,
    output wb_t    wb
);

    // valid and tag ride alongside the data stages
    logic [MUL_LATENCY-1:0] valid_q;
    logic [ROB_IDX_W-1:0]   tag_q [MUL_LATENCY];

    // stage 1 partial products, only the low 32 bits of the product matter
    logic [31:0] part_lo_q;
    logic [15:0] part_hi_q;
    // stage 2 sum, stage 3 output
    logic [31:0] sum_q;
    logic [31:0] prod_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_LATENCY-2:0], issue.valid};
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= issue.tag[ROB_IDX_W-1:0];
        for (int i = 1; i < MUL_LATENCY; i++) begin
            tag_q[i] <= tag_q[i-1];
        end

        part_lo_q <= 32'(issue.opnd_a[15:0] * issue.opnd_b);
        part_hi_q <= 16'(issue.opnd_a[31:16] * issue.opnd_b[15:0]);

        sum_q  <= part_lo_q + {part_hi_q, 16'd0};
        prod_q <= sum_q;
    end

    assign wb = '{valid: valid_q[MUL_LATENCY-1],
                  tag:   MAX_TAG_W'(tag_q[MUL_LATENCY-1]),
                  value: prod_q};

endmodule

//--- hdl/ooo_backend.sv
module ooo_backend
    import ooo_pkg::*;
#(
    parameter int ROB_IDX_W = 2
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  instr_t  in_instr,
    output logic    in_ready,
    output commit_t commit
);

    logic                 alloc_valid;
    logic [4:0]           alloc_rd;
    logic [ROB_IDX_W-1:0] alloc_tag;
    logic                 alloc_full;

    logic                 issue_valid;
    logic [4:0]           issue_rd;
    logic [ROB_IDX_W-1:0] issue_tag;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [31:0]          rs1_value;
    logic [31:0]          rs2_value;
    logic                 rs1_ready;
    logic                 rs2_ready;
    logic [ROB_IDX_W-1:0] rs1_tag;
    logic [ROB_IDX_W-1:0] rs2_tag;

    logic [ROB_IDX_W-1:0] lookup_tag_a;
    logic [ROB_IDX_W-1:0] lookup_tag_b;
    logic                 lookup_done_a;
    logic                 lookup_done_b;
    logic [31:0]          lookup_value_a;
    logic [31:0]          lookup_value_b;

    issue_t alu_issue;
    issue_t mul_issue;
    wb_t    alu_wb;
    wb_t    mul_wb;

    dispatch_unit #(.ROB_IDX_W(ROB_IDX_W)) u_dispatch (
        .clk, .rst, .in_valid, .in_instr, .in_ready,
        .alloc_valid, .alloc_rd, .alloc_tag, .alloc_full,
        .issue_valid, .issue_rd, .issue_tag, .rs1, .rs2,
        .rs1_value, .rs2_value, .rs1_ready, .rs2_ready, .rs1_tag, .rs2_tag,
        .lookup_tag_a, .lookup_tag_b, .lookup_done_a, .lookup_done_b,
        .lookup_value_a, .lookup_value_b, .alu_issue, .mul_issue
    );

    int_alu #(.ROB_IDX_W(ROB_IDX_W)) u_alu (
        .clk, .rst, .issue(alu_issue), .wb(alu_wb)
    );

    mul_unit #(.ROB_IDX_W(ROB_IDX_W)) u_mul (
        .clk, .rst, .issue(mul_issue), .wb(mul_wb)
    );

    reorder_buffer #(.ROB_IDX_W(ROB_IDX_W)) u_rob (
        .clk, .rst, .alloc_valid, .alloc_rd, .alloc_tag, .alloc_full,
        .alu_wb, .mul_wb, .lookup_tag_a, .lookup_tag_b,
        .lookup_done_a, .lookup_done_b, .lookup_value_a, .lookup_value_b,
        .commit
    );

    regfile_scoreboard #(.ROB_IDX_W(ROB_IDX_W)) u_regfile (
        .clk, .rst, .commit, .issue_valid, .issue_rd, .issue_tag,
        .rs1, .rs2, .rs1_value, .rs2_value, .rs1_ready, .rs2_ready, .rs1_tag, .rs2_tag
    );

endmodule

//--- tb/tb_ooo_backend.sv
module tb_ooo_backend
    import ooo_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROB_IDX_W        = 2;
    localparam int ROB_DEPTH        = 1 << ROB_IDX_W;
    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 16;
    localparam int DIRECTED_INSTR   = 37;
    localparam int RANDOM_INSTR     = 200;
    localparam int CYCLES_PER_INSTR = 20;
    localparam int DRAIN_CYCLES     = CYCLES_PER_INSTR * ROB_DEPTH;
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES +
        (DIRECTED_INSTR + RANDOM_INSTR) * CYCLES_PER_INSTR + 500;

    logic    clk;
    logic    rst;
    logic    in_valid;
    instr_t  in_instr;
    logic    in_ready;
    commit_t commit;

    // program-order view of the architectural registers
    logic [31:0] model_regs [32];
    commit_t     expect_q [$];
    int          sent_count = 0;
    int          commit_count = 0;
    int          stall_count = 0;
    string       test_name = "reset";

    ooo_backend #(.ROB_IDX_W(ROB_IDX_W)) UUT (
        .clk, .rst, .in_valid, .in_instr, .in_ready, .commit
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] model_result(opcode_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            op_add, op_addi: return a + b;
            op_sub:          return a - b;
            op_and:          return a & b;
            op_or:           return a | b;
            op_xor:          return a ^ b;
            // only the low word of the product is kept
            op_mul:          return a * b;
            default:         return 32'd0;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failing check");
    endtask

    task automatic compare_commit(string name, commit_t exp, commit_t act);
        if (act.rd !== exp.rd || act.tag !== exp.tag) begin
            $display("error: %s commit expected rd %0d tag %0d actual rd %0d tag %0d",
                     name, exp.rd, exp.tag, act.rd, act.tag);
            stop_with_failure();
        end
    endtask

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("error: %s value expected 0x%08h actual 0x%08h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic compare_count(string name, int exp, int act);
        if (act != exp) begin
            $display("error: %s commit count expected %0d actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    // retirement checker, one sample per cycle where commit is settled
    always @(negedge clk) begin
        commit_t expected;
        if (!rst && commit.valid) begin
            if (expect_q.size() == 0) begin
                $display("%s: a commit of rd %0d arrived with nothing outstanding",
                         test_name, commit.rd);
                stop_with_failure();
            end else begin
                expected = expect_q.pop_front();
                compare_commit(test_name, expected, commit);
                compare_value(test_name, expected.value, commit.value);
                commit_count++;
            end
        end
        if (!rst && in_valid && !in_ready) begin
            stall_count++;
        end
    end

    // drive one instruction and hold it until it is accepted
    task automatic send(opcode_e op, int rd, int rs1, int rs2, logic [31:0] imm);
        commit_t     exp;
        logic [31:0] a;
        logic [31:0] b;
        in_instr = '{op: op, rd: 5'(rd), rs1: 5'(rs1), rs2: 5'(rs2), imm: imm};
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        a = model_regs[rs1];
        b = (op == op_addi) ? imm : model_regs[rs2];
        exp.valid = 1'b1;
        exp.rd    = 5'(rd);
        exp.value = model_result(op, a, b);
        // tags hand out in allocation order around the buffer
        exp.tag   = MAX_TAG_W'(sent_count % ROB_DEPTH);
        if (rd != 0) begin
            model_regs[rd] = exp.value;
        end
        expect_q.push_back(exp);
        sent_count++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle(int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    // bounded wait for the outstanding commits
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);
        @(posedge clk);
        #1;
        compare_count(test_name, sent_count, commit_count);
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        if (!in_ready || commit.valid) begin
            $display("after reset in_ready is %0b and commit.valid is %0b, expected 1 and 0",
                     in_ready, commit.valid);
            stop_with_failure();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic independent_alu_ops();
        test_name = "independent_alu_ops";
        send(op_addi, 1, 0, 0, 32'd100);
        send(op_addi, 2, 0, 0, 32'hffff_fffd);
        send(op_addi, 3, 0, 0, 32'h0000_55aa);
        send(op_addi, 4, 0, 0, 32'h1234_0f0f);
        wait_drain();
        send(op_add, 5, 1, 2, 32'd0);
        send(op_sub, 6, 1, 3, 32'd0);
        send(op_and, 7, 3, 4, 32'd0);
        send(op_or, 8, 2, 4, 32'd0);
        send(op_xor, 9, 3, 4, 32'd0);
        wait_drain();
    endtask

    task automatic raw_chain();
        test_name = "raw_chain";
        send(op_addi, 10, 9, 0, 32'd7);
        send(op_add, 11, 10, 10, 32'd0);
        send(op_sub, 12, 11, 1, 32'd0);
        send(op_xor, 13, 12, 11, 32'd0);
        send(op_or, 14, 13, 12, 32'd0);
        send(op_and, 15, 14, 3, 32'd0);
        send(op_addi, 16, 15, 0, 32'hffff_ffff);
        send(op_add, 17, 16, 15, 32'd0);
        wait_drain();
    endtask

    task automatic mul_then_alu();
        test_name = "mul_then_alu";
        send(op_addi, 18, 0, 0, 32'hdead_beef);
        send(op_addi, 19, 0, 0, 32'h1234_5678);
        wait_drain();
        // younger ALU results finish first but retire behind the multiply
        send(op_mul, 20, 18, 19, 32'd0);
        send(op_addi, 21, 0, 0, 32'd9);
        send(op_xor, 22, 1, 2, 32'd0);
        send(op_or, 23, 3, 4, 32'd0);
        send(op_sub, 24, 4, 1, 32'd0);
        wait_drain();
    endtask

    task automatic reg0_and_waw();
        test_name = "reg0_and_waw";
        send(op_addi, 0, 0, 0, 32'd55);
        send(op_add, 25, 0, 0, 32'd0);
        send(op_add, 0, 1, 2, 32'd0);
        send(op_addi, 26, 0, 0, 32'd1);
        wait_drain();
        // older multiply and younger addi both target r27
        send(op_mul, 27, 18, 19, 32'd0);
        send(op_addi, 27, 0, 0, 32'd42);
        send(op_add, 28, 27, 27, 32'd0);
        wait_drain();
    endtask

    task automatic mul_burst();
        int stalls_before;
        test_name = "mul_burst";
        stalls_before = stall_count;
        send(op_mul, 29, 18, 19, 32'd0);
        send(op_mul, 30, 1, 18, 32'd0);
        send(op_mul, 31, 19, 2, 32'd0);
        send(op_mul, 5, 3, 4, 32'd0);
        send(op_mul, 6, 18, 18, 32'd0);
        send(op_mul, 7, 19, 19, 32'd0);
        wait_drain();
        if (stall_count == stalls_before) begin
            $display("mul_burst: in_ready never dropped although the reorder buffer filled up");
            stop_with_failure();
        end
    endtask

    task automatic random_program();
        opcode_e     op;
        int          rd;
        int          rs1;
        int          rs2;
        logic [31:0] imm;
        test_name = "random_program";
        for (int i = 0; i < RANDOM_INSTR; i++) begin
            op  = opcode_e'($urandom_range(6, 0));
            rd  = int'($urandom_range(31, 0));
            rs1 = int'($urandom_range(31, 0));
            rs2 = int'($urandom_range(31, 0));
            imm = $urandom;
            send(op, rd, rs1, rs2, imm);
            // gaps of a few cycles with in_valid low
            if ($urandom_range(3, 0) == 0) begin
                idle(int'($urandom_range(3, 1)));
            end
        end
        wait_drain();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h9d02));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset_state();
        independent_alu_ops();
        raw_chain();
        mul_then_alu();
        reg0_and_waw();
        mul_burst();
        random_program();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- verilog.f
hdl/ooo_pkg.sv
hdl/regfile_scoreboard.sv
hdl/reorder_buffer.sv
hdl/dispatch_unit.sv
hdl/int_alu.sv
hdl/mul_unit.sv
hdl/ooo_backend.sv
tb/tb_ooo_backend.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_ooo_backend
RTL_TOP   ?= ooo_backend
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
